//--- verilog/l2_cfg_pkg.sv
// ------------------------------
// l2 local storage geometry
// ------------------------------

`default_nettype none

package l2_cfg_pkg;

    // cache shape
    localparam int NUM_WAYS  = 4;
    localparam int WAY_BITS  = 2;
    localparam int SET_BITS  = 6;
    localparam int NUM_SETS  = 64;
    localparam int TAG_BITS  = 10;
    localparam int LINE_BITS = 32;

    // coherence state encoding width
    localparam int STATE_BITS = 3;

    // request queue, depth equals the sender's initial credits
    localparam int QUEUE_DEPTH    = 4;
    localparam int QUEUE_PTR_BITS = 2;
    localparam int QUEUE_CNT_BITS = 3;

    // sized constants for compares
    localparam logic [QUEUE_CNT_BITS-1:0] QUEUE_FULL = QUEUE_CNT_BITS'(QUEUE_DEPTH);
    localparam logic [SET_BITS-1:0]       LAST_SET   = SET_BITS'(NUM_SETS - 1);

endpackage

`default_nettype wire

//--- verilog/l2_msg_pkg.sv
// ------------------------------
// l2 request and response types
// ------------------------------

`default_nettype none

package l2_msg_pkg;

    typedef enum logic [2:0] {
        OP_READ     = 3'd0,
        OP_WR_LINE  = 3'd1,
        OP_WR_STATE = 3'd2,
        OP_WR_EVICT = 3'd3,
        OP_PUT      = 3'd4
    } l2_op_e;

    // invalid must stay at zero, the sweep relies on it
    typedef enum logic [l2_cfg_pkg::STATE_BITS-1:0] {
        ST_INVALID = 3'd0,
        ST_VALID   = 3'd1,
        ST_SHARED  = 3'd2,
        ST_OWNED   = 3'd3,
        ST_DIRTY   = 3'd4
    } l2_state_e;

    typedef struct packed {
        l2_op_e                          op;
        logic [l2_cfg_pkg::SET_BITS-1:0]  set;
        logic [l2_cfg_pkg::WAY_BITS-1:0]  way;
        logic [l2_cfg_pkg::TAG_BITS-1:0]  tag;
        logic [l2_cfg_pkg::LINE_BITS-1:0] line;
        logic                            hprot;
        l2_state_e                       state;
        logic [l2_cfg_pkg::WAY_BITS-1:0]  evict_way;
    } l2_req_t;

    // contents of one way at one set
    typedef struct packed {
        logic [l2_cfg_pkg::TAG_BITS-1:0]  tag;
        l2_state_e                       state;
        logic                            hprot;
        logic [l2_cfg_pkg::LINE_BITS-1:0] line;
    } l2_entry_t;

    typedef struct packed {
        logic [l2_cfg_pkg::SET_BITS-1:0] set;
        logic                           rd_en;
        logic [l2_cfg_pkg::NUM_WAYS-1:0] wr_line;
        logic [l2_cfg_pkg::NUM_WAYS-1:0] wr_state;
        logic [l2_cfg_pkg::NUM_WAYS-1:0] wr_tag_hprot;
        logic                           wr_evict;
        l2_entry_t                      wdata;
        logic [l2_cfg_pkg::WAY_BITS-1:0] evict_way;
    } l2_mem_cmd_t;

    typedef struct packed {
        l2_entry_t [l2_cfg_pkg::NUM_WAYS-1:0] entries;
        logic [l2_cfg_pkg::WAY_BITS-1:0]      evict_way;
    } l2_rsp_t;

endpackage

`default_nettype wire

//--- verilog/l2_req_queue.sv
// ------------------------------
// credit fed request queue
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module l2_req_queue (
    input  logic                clk,
    input  logic                wr_rst,
    input  logic                req_valid,
    input  l2_msg_pkg::l2_req_t req,
    input  logic                pop,
    output l2_msg_pkg::l2_req_t head,
    output logic                not_empty,
    output logic                req_credit
);

    l2_msg_pkg::l2_req_t                  mem [l2_cfg_pkg::QUEUE_DEPTH];
    logic [l2_cfg_pkg::QUEUE_PTR_BITS-1:0] wr_ptr;
    logic [l2_cfg_pkg::QUEUE_PTR_BITS-1:0] rd_ptr;
    logic [l2_cfg_pkg::QUEUE_CNT_BITS-1:0] count;
    logic                                  push;

    // a sender out of credits finds the queue full and is dropped
    assign push      = req_valid && (count != l2_cfg_pkg::QUEUE_FULL);
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per freed entry
            req_credit <= pop;
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_set_counter.sv
// ------------------------------
// sweep set counter
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module l2_set_counter (
    input  logic                            clk,
    input  logic                            wr_rst,
    input  logic                            cnt_en,
    output logic [l2_cfg_pkg::SET_BITS-1:0] count,
    output logic                            last
);

    assign last = (count == l2_cfg_pkg::LAST_SET);

    // saturates on the last set
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            count <= '0;
        end else if (cnt_en && !last) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_ctrl_fsm.sv
// ------------------------------
// l2 storage controller
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_fsm (
    input  logic                            clk,
    input  logic                            wr_rst,
    input  l2_msg_pkg::l2_req_t             head,
    input  logic                            not_empty,
    input  logic [l2_cfg_pkg::SET_BITS-1:0] count,
    input  logic                            last,
    output logic                            pop,
    output logic                            cnt_en,
    output l2_msg_pkg::l2_mem_cmd_t         cmd,
    output logic                            rsp_valid,
    output logic                            init_done
);

    typedef enum logic {
        SWEEP,
        SERVE
    } fsm_state_e;

    fsm_state_e                      state;
    logic [l2_cfg_pkg::NUM_WAYS-1:0] way_mask;

    always_comb begin
        way_mask = '0;
        way_mask[head.way] = 1'b1;
    end

    always_comb begin
        pop    = 1'b0;
        cnt_en = 1'b0;
        cmd    = '0;

        cmd.set          = head.set;
        cmd.wdata.tag    = head.tag;
        cmd.wdata.state  = head.state;
        cmd.wdata.hprot  = head.hprot;
        cmd.wdata.line   = head.line;
        cmd.evict_way    = head.evict_way;

        if (state == SWEEP) begin
            // invalidate every way of one set per cycle
            cnt_en          = 1'b1;
            cmd.set         = count;
            cmd.wr_state    = '1;
            cmd.wdata.state = l2_msg_pkg::ST_INVALID;
        end else if (not_empty) begin
            pop = 1'b1;
            case (head.op)
                l2_msg_pkg::OP_READ:     cmd.rd_en    = 1'b1;
                l2_msg_pkg::OP_WR_LINE:  cmd.wr_line  = way_mask;
                l2_msg_pkg::OP_WR_STATE: cmd.wr_state = way_mask;
                l2_msg_pkg::OP_WR_EVICT: cmd.wr_evict = 1'b1;
                l2_msg_pkg::OP_PUT: begin
                    cmd.wr_line      = way_mask;
                    cmd.wr_state     = way_mask;
                    cmd.wr_tag_hprot = way_mask;
                end
                default: cmd.rd_en = 1'b0;
            endcase
        end
    end

    assign init_done = (state == SERVE);

    always_ff @(posedge clk) begin
        if (wr_rst) begin
            state     <= SWEEP;
            rsp_valid <= 1'b0;
        end else begin
            if (state == SWEEP && last) begin
                state <= SERVE;
            end
            // array read data lands together with this
            rsp_valid <= cmd.rd_en;
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_way_array.sv
// ------------------------------
// single way storage
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module l2_way_array (
    input  logic                    clk,
    input  l2_msg_pkg::l2_mem_cmd_t cmd,
    input  logic                    wr_line,
    input  logic                    wr_state,
    input  logic                    wr_tag_hprot,
    output l2_msg_pkg::l2_entry_t   entry
);

    logic [l2_cfg_pkg::LINE_BITS-1:0] line_mem  [l2_cfg_pkg::NUM_SETS];
    l2_msg_pkg::l2_state_e            state_mem [l2_cfg_pkg::NUM_SETS];
    logic [l2_cfg_pkg::TAG_BITS-1:0]  tag_mem   [l2_cfg_pkg::NUM_SETS];
    logic                             hprot_mem [l2_cfg_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (wr_line) begin
            line_mem[cmd.set] <= cmd.wdata.line;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_state) begin
            state_mem[cmd.set] <= cmd.wdata.state;
        end
    end

    // tag and hprot only change together, on a put
    always_ff @(posedge clk) begin
        if (wr_tag_hprot) begin
            tag_mem[cmd.set]   <= cmd.wdata.tag;
            hprot_mem[cmd.set] <= cmd.wdata.hprot;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.rd_en) begin
            entry.tag   <= tag_mem[cmd.set];
            entry.state <= state_mem[cmd.set];
            entry.hprot <= hprot_mem[cmd.set];
            entry.line  <= line_mem[cmd.set];
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_evict_array.sv
// ------------------------------
// eviction way storage
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module l2_evict_array (
    input  logic                            clk,
    input  l2_msg_pkg::l2_mem_cmd_t         cmd,
    output logic [l2_cfg_pkg::WAY_BITS-1:0] evict_way
);

    // next victim way, one per set
    logic [l2_cfg_pkg::WAY_BITS-1:0] evict_mem [l2_cfg_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (cmd.wr_evict) begin
            evict_mem[cmd.set] <= cmd.evict_way;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.rd_en) begin
            evict_way <= evict_mem[cmd.set];
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_localmem_top.sv
// ------------------------------
// l2 local memory top
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module l2_localmem_top (
    input  logic                clk,
    input  logic                wr_rst,
    input  logic                req_valid,
    input  l2_msg_pkg::l2_req_t req,
    output logic                req_credit,
    output logic                rsp_valid,
    output l2_msg_pkg::l2_rsp_t rsp,
    output logic                init_done
);

    l2_msg_pkg::l2_req_t             head;
    logic                            not_empty;
    logic                            pop;
    logic                            cnt_en;
    logic [l2_cfg_pkg::SET_BITS-1:0] count;
    logic                            last;
    l2_msg_pkg::l2_mem_cmd_t         cmd;
    l2_msg_pkg::l2_entry_t           way_entry [l2_cfg_pkg::NUM_WAYS];
    logic [l2_cfg_pkg::WAY_BITS-1:0] evict_way;

    l2_req_queue u_queue (
        .clk        (clk),
        .wr_rst     (wr_rst),
        .req_valid  (req_valid),
        .req        (req),
        .pop        (pop),
        .head       (head),
        .not_empty  (not_empty),
        .req_credit (req_credit)
    );

    l2_set_counter u_set_counter (
        .clk    (clk),
        .wr_rst (wr_rst),
        .cnt_en (cnt_en),
        .count  (count),
        .last   (last)
    );

    l2_ctrl_fsm u_ctrl (
        .clk       (clk),
        .wr_rst    (wr_rst),
        .head      (head),
        .not_empty (not_empty),
        .count     (count),
        .last      (last),
        .pop       (pop),
        .cnt_en    (cnt_en),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .init_done (init_done)
    );

    // each way takes its own bit of the write masks
    for (genvar w = 0; w < l2_cfg_pkg::NUM_WAYS; w++) begin : g_way
        l2_way_array u_way (
            .clk          (clk),
            .cmd          (cmd),
            .wr_line      (cmd.wr_line[w]),
            .wr_state     (cmd.wr_state[w]),
            .wr_tag_hprot (cmd.wr_tag_hprot[w]),
            .entry        (way_entry[w])
        );
    end

    l2_evict_array u_evict (
        .clk       (clk),
        .cmd       (cmd),
        .evict_way (evict_way)
    );

    always_comb begin
        rsp.evict_way = evict_way;
        for (int i = 0; i < l2_cfg_pkg::NUM_WAYS; i++) begin
            rsp.entries[i] = way_entry[i];
        end
    end

endmodule

`default_nettype wire

//--- tests/l2_localmem_tb.sv
// ------------------------------
// l2 local memory testbench
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module l2_localmem_tb;

    // one expected response and which of its fields are known
    typedef struct packed {
        l2_msg_pkg::l2_rsp_t             rsp;
        logic [l2_cfg_pkg::NUM_WAYS-1:0] tag_k;
        logic [l2_cfg_pkg::NUM_WAYS-1:0] line_k;
        logic [l2_cfg_pkg::NUM_WAYS-1:0] hprot_k;
        logic                            evict_k;
    } expect_t;

    logic                clk;
    logic                wr_rst;
    logic                req_valid;
    l2_msg_pkg::l2_req_t req;
    logic                req_credit;
    logic                rsp_valid;
    l2_msg_pkg::l2_rsp_t rsp;
    logic                init_done;

    // reference model, per way and per field
    logic [l2_cfg_pkg::TAG_BITS-1:0]  m_tag   [l2_cfg_pkg::NUM_WAYS][l2_cfg_pkg::NUM_SETS];
    logic [l2_cfg_pkg::LINE_BITS-1:0] m_line  [l2_cfg_pkg::NUM_WAYS][l2_cfg_pkg::NUM_SETS];
    logic                             m_hprot [l2_cfg_pkg::NUM_WAYS][l2_cfg_pkg::NUM_SETS];
    l2_msg_pkg::l2_state_e            m_state [l2_cfg_pkg::NUM_WAYS][l2_cfg_pkg::NUM_SETS];
    logic [l2_cfg_pkg::WAY_BITS-1:0]  m_evict [l2_cfg_pkg::NUM_SETS];
    bit tag_known   [l2_cfg_pkg::NUM_WAYS][l2_cfg_pkg::NUM_SETS];
    bit line_known  [l2_cfg_pkg::NUM_WAYS][l2_cfg_pkg::NUM_SETS];
    bit hprot_known [l2_cfg_pkg::NUM_WAYS][l2_cfg_pkg::NUM_SETS];
    bit evict_known [l2_cfg_pkg::NUM_SETS];

    l2_msg_pkg::l2_req_t stim [$];
    expect_t             exp_q [$];
    expect_t             got_exp;
    integer              seed           = 55414;
    int                  timeout_cycles = 400;
    int                  sent           = 0;
    int                  reads_sent     = 0;
    int                  credit_pulses  = 0;
    int                  rsp_count      = 0;
    int                  value_errors   = 0;
    int                  rsp_errors     = 0;
    int                  flow_errors    = 0;
    int                  timeouts       = 0;

    l2_localmem_top uut (
        .clk        (clk),
        .wr_rst     (wr_rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .init_done  (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int credits_held();
        return l2_cfg_pkg::QUEUE_DEPTH + credit_pulses - sent;
    endfunction

    // tag, hprot and evict way are taken from bits of the data word
    function automatic l2_msg_pkg::l2_req_t make_req(
        input l2_msg_pkg::l2_op_e              op,
        input logic [l2_cfg_pkg::SET_BITS-1:0] set,
        input logic [l2_cfg_pkg::WAY_BITS-1:0] way,
        input logic [31:0]                     data,
        input l2_msg_pkg::l2_state_e           state
    );
        l2_msg_pkg::l2_req_t r;
        r.op        = op;
        r.set       = set;
        r.way       = way;
        r.tag       = data[19:10];
        r.line      = data;
        r.hprot     = data[0];
        r.state     = state;
        r.evict_way = data[1:0];
        return r;
    endfunction

    task automatic print_counts();
        $display("errors: value %0d response %0d flow %0d timeout %0d; sent %0d got %0d",
                 value_errors, rsp_errors, flow_errors, timeouts, sent, rsp_count);
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s at %0t", what, $time);
        timeouts++;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED %0t %s got %0h expected %0h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic compare_rsp(input expect_t e);
        for (int w = 0; w < l2_cfg_pkg::NUM_WAYS; w++) begin
            check_field($sformatf("rsp.entries[%0d].state", w),
                        32'(rsp.entries[w].state), 32'(e.rsp.entries[w].state));
            if (e.tag_k[w]) begin
                check_field($sformatf("rsp.entries[%0d].tag", w),
                            32'(rsp.entries[w].tag), 32'(e.rsp.entries[w].tag));
            end
            if (e.line_k[w]) begin
                check_field($sformatf("rsp.entries[%0d].line", w),
                            rsp.entries[w].line, e.rsp.entries[w].line);
            end
            if (e.hprot_k[w]) begin
                check_field($sformatf("rsp.entries[%0d].hprot", w),
                            32'(rsp.entries[w].hprot), 32'(e.rsp.entries[w].hprot));
            end
        end
        if (e.evict_k) begin
            check_field("rsp.evict_way", 32'(rsp.evict_way), 32'(e.rsp.evict_way));
        end
    endtask

    // requests are served in order, so the model is updated at send time
    task automatic apply_to_model(input l2_msg_pkg::l2_req_t r);
        expect_t e;
        e = '0;
        case (r.op)
            l2_msg_pkg::OP_READ: begin
                for (int w = 0; w < l2_cfg_pkg::NUM_WAYS; w++) begin
                    e.rsp.entries[w].tag   = m_tag[w][r.set];
                    e.rsp.entries[w].line  = m_line[w][r.set];
                    e.rsp.entries[w].hprot = m_hprot[w][r.set];
                    e.rsp.entries[w].state = m_state[w][r.set];
                    e.tag_k[w]   = tag_known[w][r.set];
                    e.line_k[w]  = line_known[w][r.set];
                    e.hprot_k[w] = hprot_known[w][r.set];
                end
                e.rsp.evict_way = m_evict[r.set];
                e.evict_k       = evict_known[r.set];
                exp_q.push_back(e);
                reads_sent++;
            end
            l2_msg_pkg::OP_WR_LINE: begin
                m_line[r.way][r.set]     = r.line;
                line_known[r.way][r.set] = 1'b1;
            end
            l2_msg_pkg::OP_WR_STATE: begin
                m_state[r.way][r.set] = r.state;
            end
            l2_msg_pkg::OP_WR_EVICT: begin
                m_evict[r.set]     = r.evict_way;
                evict_known[r.set] = 1'b1;
            end
            l2_msg_pkg::OP_PUT: begin
                m_tag[r.way][r.set]       = r.tag;
                m_line[r.way][r.set]      = r.line;
                m_hprot[r.way][r.set]     = r.hprot;
                m_state[r.way][r.set]     = r.state;
                tag_known[r.way][r.set]   = 1'b1;
                line_known[r.way][r.set]  = 1'b1;
                hprot_known[r.way][r.set] = 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic build_stimulus();
        logic [31:0]           rnd;
        l2_msg_pkg::l2_op_e    op;
        l2_msg_pkg::l2_state_e st;
        // fresh sets after the sweep
        stim.push_back(make_req(l2_msg_pkg::OP_READ, 6'd5, 2'd0, 32'h0,
                                l2_msg_pkg::ST_VALID));
        stim.push_back(make_req(l2_msg_pkg::OP_READ, 6'd63, 2'd0, 32'h0,
                                l2_msg_pkg::ST_VALID));
        stim.push_back(make_req(l2_msg_pkg::OP_PUT, 6'd5, 2'd1, 32'hdeadbeef,
                                l2_msg_pkg::ST_VALID));
        stim.push_back(make_req(l2_msg_pkg::OP_PUT, 6'd5, 2'd3, 32'h12345678,
                                l2_msg_pkg::ST_DIRTY));
        stim.push_back(make_req(l2_msg_pkg::OP_READ, 6'd5, 2'd0, 32'h0,
                                l2_msg_pkg::ST_VALID));
        // line only, then state only
        stim.push_back(make_req(l2_msg_pkg::OP_WR_LINE, 6'd5, 2'd1, 32'hcafef00d,
                                l2_msg_pkg::ST_OWNED));
        stim.push_back(make_req(l2_msg_pkg::OP_WR_STATE, 6'd5, 2'd3, 32'h0,
                                l2_msg_pkg::ST_SHARED));
        stim.push_back(make_req(l2_msg_pkg::OP_READ, 6'd5, 2'd0, 32'h0,
                                l2_msg_pkg::ST_VALID));
        stim.push_back(make_req(l2_msg_pkg::OP_WR_EVICT, 6'd5, 2'd0, 32'h2,
                                l2_msg_pkg::ST_VALID));
        stim.push_back(make_req(l2_msg_pkg::OP_WR_EVICT, 6'd9, 2'd0, 32'h1,
                                l2_msg_pkg::ST_VALID));
        stim.push_back(make_req(l2_msg_pkg::OP_READ, 6'd5, 2'd0, 32'h0,
                                l2_msg_pkg::ST_VALID));
        stim.push_back(make_req(l2_msg_pkg::OP_READ, 6'd9, 2'd0, 32'h0,
                                l2_msg_pkg::ST_VALID));
        // mixed opcodes kept to eight sets so reads meet earlier writes
        for (int i = 0; i < 48; i++) begin
            rnd = $random(seed);
            op  = l2_msg_pkg::l2_op_e'(rnd[2:0] % 3'd5);
            st  = l2_msg_pkg::l2_state_e'(rnd[5:3] % 3'd5);
            stim.push_back(make_req(op, {3'd0, rnd[8:6]}, rnd[10:9], $random(seed), st));
        end
    endtask

    task automatic wait_for_init();
        int n;
        n = 0;
        while (!init_done && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!init_done) begin
            report_timeout("init_done after reset");
        end else begin
            assert (n == l2_cfg_pkg::NUM_SETS) else begin
                $display("sweep took %0d cycles instead of %0d", n, l2_cfg_pkg::NUM_SETS);
                flow_errors++;
            end
        end
    endtask

    task automatic send_req(input l2_msg_pkg::l2_req_t r);
        int n;
        n = 0;
        while (credits_held() == 0 && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (credits_held() == 0) begin
            report_timeout("a request credit");
        end else begin
            req_valid = 1'b1;
            req       = r;
            sent++;
            apply_to_model(r);
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end
    endtask

    task automatic send_all();
        for (int i = 0; i < stim.size() && timeouts == 0; i++) begin
            send_req(stim[i]);
        end
    endtask

    task automatic wait_for_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || credit_pulses != sent) && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0 || credit_pulses != sent) begin
            report_timeout("outstanding responses and credits");
        end
    endtask

    // outputs are sampled at the falling edge
    always @(negedge clk) begin
        if (req_credit) begin
            credit_pulses++;
            assert (init_done) else begin
                $display("credit returned before serving started at %0t", $time);
                flow_errors++;
            end
            assert (credits_held() <= l2_cfg_pkg::QUEUE_DEPTH) else begin
                $display("more credits returned than requests sent at %0t", $time);
                rsp_errors++;
            end
        end
        if (rsp_valid) begin
            rsp_count++;
            assert (exp_q.size() != 0) else begin
                $display("response at %0t with no read outstanding", $time);
                rsp_errors++;
            end
            if (exp_q.size() != 0) begin
                got_exp = exp_q.pop_front();
                compare_rsp(got_exp);
            end
        end
    end

    initial begin
        wr_rst    = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        for (int w = 0; w < l2_cfg_pkg::NUM_WAYS; w++) begin
            for (int s = 0; s < l2_cfg_pkg::NUM_SETS; s++) begin
                m_state[w][s] = l2_msg_pkg::ST_INVALID;
            end
        end
        build_stimulus();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            assert (!req_credit && !rsp_valid && !init_done) else begin
                $display("outputs not low during reset at %0t", $time);
                flow_errors++;
            end
        end
        wr_rst = 1'b0;
        // the first requests fill the queue while the sweep runs
        fork
            wait_for_init();
            send_all();
        join
        if (timeouts == 0) begin
            wait_for_drain();
        end
        if (timeouts == 0) begin
            // quiet period to catch stray responses
            repeat (8) @(posedge clk);
            assert (rsp_count == reads_sent) else begin
                $display("got %0d responses for %0d reads", rsp_count, reads_sent);
                flow_errors++;
            end
        end
        print_counts();
        if (value_errors + rsp_errors + flow_errors + timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/l2_cfg_pkg.sv
verilog/l2_msg_pkg.sv
verilog/l2_req_queue.sv
verilog/l2_set_counter.sv
verilog/l2_ctrl_fsm.sv
verilog/l2_way_array.sv
verilog/l2_evict_array.sv
verilog/l2_localmem_top.sv
tests/l2_localmem_tb.sv

//--- run.sh
#!/bin/sh
# build and run the l2 local memory testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module l2_localmem_tb \
    -o l2_localmem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/l2_localmem_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
